// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP      = tb_rs
FILELIST = project.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== project.f ====
rs_pkg.sv
rs_operand_bypass.sv
rs_entry.sv
rs_alloc.sv
rs_fu_credits.sv
rs_issue_select.sv
rs_top.sv
tb_rs.sv

// ==== rs_alloc.sv ====
// dispatch allocation
//   lowest free entry to slot 1, next one to slot 2
//   free level saturated at two

module rs_alloc (
	input  logic [rs_pkg::RS_SIZE-1:0]  busy,
	input  logic                        inst1_valid,
	input  logic                        inst2_valid,
	output logic [rs_pkg::RS_SIZE-1:0]  load1,
	output logic [rs_pkg::RS_SIZE-1:0]  load2,
	output logic [rs_pkg::FREE_W-1:0]   free_level
);
	import rs_pkg::*;

	logic [RS_SIZE-1:0] first, second;	// one-hot, or zero if none
	logic [FREE_W-1:0]  free_cnt;

	always_comb begin
		first    = '0;
		second   = '0;
		free_cnt = '0;
		for (int i = 0; i < RS_SIZE; i++) begin
			if (!busy[i]) begin
				if (free_cnt == 2'd0)
					first[i] = 1'b1;
				else if (free_cnt == 2'd1)
					second[i] = 1'b1;
				if (free_cnt != 2'd2)
					free_cnt = free_cnt + 2'd1;
			end
		end
	end

	// a lone slot 2 takes the lowest entry
	assign load1      = inst1_valid ? first : '0;
	assign load2      = !inst2_valid ? '0 : (inst1_valid ? second : first);
	assign free_level = free_cnt;

endmodule

// ==== rs_entry.sv ====
// one reservation station entry
//   instruction storage, loaded from either dispatch slot
//   CDB wakeup of waiting operands
//   ready, cleared on issue or on a flush of its thread

module rs_entry (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           load1,
	input  logic                           load2,
	input  logic [rs_pkg::PRF_TAG_W-1:0]   inst1_dest_tag,
	input  rs_pkg::operand_t               inst1_opa,
	input  rs_pkg::operand_t               inst1_opb,
	input  logic                           inst1_opa_ready,
	input  logic                           inst1_opb_ready,
	input  logic [rs_pkg::ROB_IDX_W-1:0]   inst1_rob_idx,
	input  logic [rs_pkg::ALU_FUNC_W-1:0]  inst1_alu_func,
	input  logic [rs_pkg::FU_CLASS_W-1:0]  inst1_fu_class,
	input  logic [rs_pkg::PRF_TAG_W-1:0]   inst2_dest_tag,
	input  rs_pkg::operand_t               inst2_opa,
	input  rs_pkg::operand_t               inst2_opb,
	input  logic                           inst2_opa_ready,
	input  logic                           inst2_opb_ready,
	input  logic [rs_pkg::ROB_IDX_W-1:0]   inst2_rob_idx,
	input  logic [rs_pkg::ALU_FUNC_W-1:0]  inst2_alu_func,
	input  logic [rs_pkg::FU_CLASS_W-1:0]  inst2_fu_class,
	input  logic                           cdb1_valid,
	input  logic [rs_pkg::PRF_TAG_W-1:0]   cdb1_tag,
	input  logic [rs_pkg::DATA_W-1:0]      cdb1_value,
	input  logic                           cdb2_valid,
	input  logic [rs_pkg::PRF_TAG_W-1:0]   cdb2_tag,
	input  logic [rs_pkg::DATA_W-1:0]      cdb2_value,
	input  logic                           issue_grant,
	input  logic [1:0]                     flush_thread,
	output logic                           busy,
	output logic                           ready,
	output logic [rs_pkg::FU_CLASS_W-1:0]  fu_class,
	output logic [rs_pkg::DATA_W-1:0]      opa_value,
	output logic [rs_pkg::DATA_W-1:0]      opb_value,
	output logic [rs_pkg::PRF_TAG_W-1:0]   dest_tag,
	output logic [rs_pkg::ROB_IDX_W-1:0]   rob_idx,
	output logic [rs_pkg::ALU_FUNC_W-1:0]  alu_func
);
	import rs_pkg::*;

	operand_t opa_q, opb_q;
	logic     opa_rdy, opb_rdy;
	logic     a_hit1, a_hit2, b_hit1, b_hit2;
	logic     flushed;

	assign a_hit1  = !opa_rdy && cdb1_valid && (opa_q.tag_view.tag == cdb1_tag);
	assign a_hit2  = !opa_rdy && cdb2_valid && (opa_q.tag_view.tag == cdb2_tag);
	assign b_hit1  = !opb_rdy && cdb1_valid && (opb_q.tag_view.tag == cdb1_tag);
	assign b_hit2  = !opb_rdy && cdb2_valid && (opb_q.tag_view.tag == cdb2_tag);
	assign flushed = busy && flush_thread[rob_idx[ROB_IDX_W-1]];

	// control state
	always_ff @(posedge clock) begin
		if (reset) begin
			busy    <= 1'b0;
			opa_rdy <= 1'b0;
			opb_rdy <= 1'b0;
		end else if (load1) begin
			busy    <= 1'b1;
			opa_rdy <= inst1_opa_ready;
			opb_rdy <= inst1_opb_ready;
		end else if (load2) begin
			busy    <= 1'b1;
			opa_rdy <= inst2_opa_ready;
			opb_rdy <= inst2_opb_ready;
		end else begin
			if (issue_grant || flushed)
				busy <= 1'b0;
			if (a_hit1 || a_hit2)
				opa_rdy <= 1'b1;	// wakeup
			if (b_hit1 || b_hit2)
				opb_rdy <= 1'b1;
		end
	end

	// payload
	always_ff @(posedge clock) begin
		if (load1) begin
			opa_q    <= inst1_opa;
			opb_q    <= inst1_opb;
			dest_tag <= inst1_dest_tag;
			rob_idx  <= inst1_rob_idx;
			alu_func <= inst1_alu_func;
			fu_class <= inst1_fu_class;
		end else if (load2) begin
			opa_q    <= inst2_opa;
			opb_q    <= inst2_opb;
			dest_tag <= inst2_dest_tag;
			rob_idx  <= inst2_rob_idx;
			alu_func <= inst2_alu_func;
			fu_class <= inst2_fu_class;
		end else begin
			if (a_hit1)
				opa_q.value <= cdb1_value;	// cdb1 first
			else if (a_hit2)
				opa_q.value <= cdb2_value;
			if (b_hit1)
				opb_q.value <= cdb1_value;
			else if (b_hit2)
				opb_q.value <= cdb2_value;
		end
	end

	assign ready     = busy && opa_rdy && opb_rdy && !flushed;
	assign opa_value = opa_q.value;
	assign opb_value = opb_q.value;

endmodule

// ==== rs_fu_credits.sv ====
// issue credit counters, one per functional unit port
//   loaded with the unit's credit grant at reset
//   minus one per issue, plus one per returned credit

module rs_fu_credits (
	input  logic                            clock,
	input  logic                            reset,
	input  logic [rs_pkg::ISSUE_PORTS-1:0]  issued,
	input  logic [rs_pkg::ISSUE_PORTS-1:0]  credit_return,
	output logic [rs_pkg::ISSUE_PORTS-1:0]  has_credit
);
	import rs_pkg::*;

	logic [CREDIT_W-1:0] count [ISSUE_PORTS];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int p = 0; p < ISSUE_PORTS; p++)
				count[p] <= CREDIT_W'(CREDITS_PER_FU);
		end else begin
			for (int p = 0; p < ISSUE_PORTS; p++) begin
				case ({issued[p], credit_return[p]})
					2'b10:   count[p] <= count[p] - 1'b1;
					2'b01:   count[p] <= count[p] + 1'b1;
					default: count[p] <= count[p];	// none, or both cancel
				endcase
			end
		end
	end

	always_comb begin
		for (int p = 0; p < ISSUE_PORTS; p++)
			has_credit[p] = (count[p] != '0);
	end

endmodule

// ==== rs_issue_select.sv ====
// issue selection
//   per port, lowest ready entry of the port's class wins
//   only while the port holds a credit
//   one-hot payload mux onto each port

module rs_issue_select (
	input  logic [rs_pkg::RS_SIZE-1:0]                            ready,
	input  logic [rs_pkg::RS_SIZE-1:0][rs_pkg::FU_CLASS_W-1:0]    fu_class,
	input  logic [rs_pkg::RS_SIZE-1:0][rs_pkg::DATA_W-1:0]        opa_value,
	input  logic [rs_pkg::RS_SIZE-1:0][rs_pkg::DATA_W-1:0]        opb_value,
	input  logic [rs_pkg::RS_SIZE-1:0][rs_pkg::PRF_TAG_W-1:0]     dest_tag,
	input  logic [rs_pkg::RS_SIZE-1:0][rs_pkg::ROB_IDX_W-1:0]     rob_idx,
	input  logic [rs_pkg::RS_SIZE-1:0][rs_pkg::ALU_FUNC_W-1:0]    alu_func,
	input  logic [rs_pkg::ISSUE_PORTS-1:0]                        has_credit,
	output logic [rs_pkg::RS_SIZE-1:0]                            issue_grant,
	output logic [rs_pkg::ISSUE_PORTS-1:0]                        issue_valid,
	output logic [rs_pkg::ISSUE_PORTS-1:0]                        issued,
	output logic [rs_pkg::ISSUE_PORTS-1:0][rs_pkg::DATA_W-1:0]    issue_opa,
	output logic [rs_pkg::ISSUE_PORTS-1:0][rs_pkg::DATA_W-1:0]    issue_opb,
	output logic [rs_pkg::ISSUE_PORTS-1:0][rs_pkg::PRF_TAG_W-1:0] issue_dest_tag,
	output logic [rs_pkg::ISSUE_PORTS-1:0][rs_pkg::ROB_IDX_W-1:0] issue_rob_idx,
	output logic [rs_pkg::ISSUE_PORTS-1:0][rs_pkg::ALU_FUNC_W-1:0] issue_alu_func
);
	import rs_pkg::*;

	localparam logic [FU_CLASS_W-1:0] PORT_CLASS [ISSUE_PORTS] = '{FU_MULT, FU_ALU, FU_MEM};

	logic [ISSUE_PORTS-1:0][RS_SIZE-1:0] req, pick;

	////////////////////////////////////////////////////////////////////
	// per-port pick
	////////////////////////////////////////////////////////////////////
	always_comb begin
		for (int p = 0; p < ISSUE_PORTS; p++) begin
			for (int i = 0; i < RS_SIZE; i++)
				req[p][i] = ready[i] && (fu_class[i] == PORT_CLASS[p]) && has_credit[p];
			pick[p] = req[p] & (~req[p] + 1'b1);	// isolate lowest set bit
		end
	end

	////////////////////////////////////////////////////////////////////
	// grants and payload mux
	////////////////////////////////////////////////////////////////////
	always_comb begin
		issue_grant    = '0;
		issue_opa      = '0;
		issue_opb      = '0;
		issue_dest_tag = '0;
		issue_rob_idx  = '0;
		issue_alu_func = '0;
		for (int p = 0; p < ISSUE_PORTS; p++) begin
			issue_valid[p] = |pick[p];
			issue_grant    = issue_grant | pick[p];	// classes are disjoint
			for (int i = 0; i < RS_SIZE; i++) begin
				if (pick[p][i]) begin
					issue_opa[p]      = opa_value[i];
					issue_opb[p]      = opb_value[i];
					issue_dest_tag[p] = dest_tag[i];
					issue_rob_idx[p]  = rob_idx[i];
					issue_alu_func[p] = alu_func[i];
				end
			end
		end
	end

	assign issued = issue_valid;	// consumes a credit

endmodule

// ==== rs_operand_bypass.sv ====
// dispatch-time operand capture
//   compares each waiting operand tag with both CDBs
//   cdb1 wins when both buses carry the same tag

module rs_operand_bypass (
	input  rs_pkg::operand_t              opa,
	input  rs_pkg::operand_t              opb,
	input  logic                          opa_ready,
	input  logic                          opb_ready,
	input  logic                          cdb1_valid,
	input  logic [rs_pkg::PRF_TAG_W-1:0]  cdb1_tag,
	input  logic [rs_pkg::DATA_W-1:0]     cdb1_value,
	input  logic                          cdb2_valid,
	input  logic [rs_pkg::PRF_TAG_W-1:0]  cdb2_tag,
	input  logic [rs_pkg::DATA_W-1:0]     cdb2_value,
	output rs_pkg::operand_t              opa_out,
	output rs_pkg::operand_t              opb_out,
	output logic                          opa_ready_out,
	output logic                          opb_ready_out
);
	import rs_pkg::*;

	logic a_hit1, a_hit2, b_hit1, b_hit2;

	// only a waiting operand holds a tag
	assign a_hit1 = !opa_ready && cdb1_valid && (opa.tag_view.tag == cdb1_tag);
	assign a_hit2 = !opa_ready && cdb2_valid && (opa.tag_view.tag == cdb2_tag);
	assign b_hit1 = !opb_ready && cdb1_valid && (opb.tag_view.tag == cdb1_tag);
	assign b_hit2 = !opb_ready && cdb2_valid && (opb.tag_view.tag == cdb2_tag);

	always_comb begin
		opa_out = opa;
		opb_out = opb;
		if (a_hit1)
			opa_out.value = cdb1_value;
		else if (a_hit2)
			opa_out.value = cdb2_value;
		if (b_hit1)
			opb_out.value = cdb1_value;
		else if (b_hit2)
			opb_out.value = cdb2_value;
	end

	assign opa_ready_out = opa_ready | a_hit1 | a_hit2;
	assign opb_ready_out = opb_ready | b_hit1 | b_hit2;

endmodule

// ==== rs_pkg.sv ====
// reservation station shared definitions
//   sizes and field widths
//   functional unit class codes, which double as issue port numbers
//   credit and free level widths
//   operand word, read as a value or as a pending register tag

package rs_pkg;

	localparam int RS_SIZE    = 8;
	localparam int PRF_TAG_W  = 6;
	localparam int DATA_W     = 64;
	localparam int ROB_IDX_W  = 5;	// msb is the thread number
	localparam int ALU_FUNC_W = 5;
	localparam int FU_CLASS_W = 2;

	// class codes, equal to the issue port numbers
	localparam logic [FU_CLASS_W-1:0] FU_MULT = 2'd0;
	localparam logic [FU_CLASS_W-1:0] FU_ALU  = 2'd1;
	localparam logic [FU_CLASS_W-1:0] FU_MEM  = 2'd2;

	localparam int ISSUE_PORTS    = 3;
	localparam int CREDITS_PER_FU = 2;	// granted by each unit after reset
	localparam int CREDIT_W       = 2;
	localparam int FREE_W         = 2;	// 0, 1 or 2-or-more free entries

	// the valid bit next to the word says which view applies
	typedef union packed {
		logic [DATA_W-1:0] value;
		struct packed {
			logic [DATA_W-PRF_TAG_W-1:0] pad;
			logic [PRF_TAG_W-1:0]        tag;
		} tag_view;
	} operand_t;

endpackage

// ==== rs_top.sv ====
// reservation station top level
//   dispatch bypass for both slots
//   entry array with allocation
//   credit counters and per-class issue selection

module rs_top (
	input  logic                                                  clock,
	input  logic                                                  reset,
	input  logic                                                  inst1_valid,
	input  logic [rs_pkg::PRF_TAG_W-1:0]                          inst1_dest_tag,
	input  rs_pkg::operand_t                                      inst1_opa,
	input  rs_pkg::operand_t                                      inst1_opb,
	input  logic                                                  inst1_opa_ready,
	input  logic                                                  inst1_opb_ready,
	input  logic [rs_pkg::ROB_IDX_W-1:0]                          inst1_rob_idx,
	input  logic [rs_pkg::ALU_FUNC_W-1:0]                         inst1_alu_func,
	input  logic [rs_pkg::FU_CLASS_W-1:0]                         inst1_fu_class,
	input  logic                                                  inst2_valid,
	input  logic [rs_pkg::PRF_TAG_W-1:0]                          inst2_dest_tag,
	input  rs_pkg::operand_t                                      inst2_opa,
	input  rs_pkg::operand_t                                      inst2_opb,
	input  logic                                                  inst2_opa_ready,
	input  logic                                                  inst2_opb_ready,
	input  logic [rs_pkg::ROB_IDX_W-1:0]                          inst2_rob_idx,
	input  logic [rs_pkg::ALU_FUNC_W-1:0]                         inst2_alu_func,
	input  logic [rs_pkg::FU_CLASS_W-1:0]                         inst2_fu_class,
	output logic [rs_pkg::FREE_W-1:0]                             free_level,
	input  logic                                                  cdb1_valid,
	input  logic [rs_pkg::PRF_TAG_W-1:0]                          cdb1_tag,
	input  logic [rs_pkg::DATA_W-1:0]                             cdb1_value,
	input  logic                                                  cdb2_valid,
	input  logic [rs_pkg::PRF_TAG_W-1:0]                          cdb2_tag,
	input  logic [rs_pkg::DATA_W-1:0]                             cdb2_value,
	input  logic [1:0]                                            flush_thread,
	input  logic [rs_pkg::ISSUE_PORTS-1:0]                        credit_return,
	output logic [rs_pkg::ISSUE_PORTS-1:0]                        issue_valid,
	output logic [rs_pkg::ISSUE_PORTS-1:0][rs_pkg::DATA_W-1:0]    issue_opa,
	output logic [rs_pkg::ISSUE_PORTS-1:0][rs_pkg::DATA_W-1:0]    issue_opb,
	output logic [rs_pkg::ISSUE_PORTS-1:0][rs_pkg::PRF_TAG_W-1:0] issue_dest_tag,
	output logic [rs_pkg::ISSUE_PORTS-1:0][rs_pkg::ROB_IDX_W-1:0] issue_rob_idx,
	output logic [rs_pkg::ISSUE_PORTS-1:0][rs_pkg::ALU_FUNC_W-1:0] issue_alu_func
);
	import rs_pkg::*;

	// bypassed dispatch operands
	operand_t b1_opa, b1_opb, b2_opa, b2_opb;
	logic     b1_opa_ready, b1_opb_ready, b2_opa_ready, b2_opb_ready;

	// entry array
	logic [RS_SIZE-1:0]                 load1, load2, busy, ready, issue_grant;
	logic [RS_SIZE-1:0][FU_CLASS_W-1:0] fu_class;
	logic [RS_SIZE-1:0][DATA_W-1:0]     opa_value, opb_value;
	logic [RS_SIZE-1:0][PRF_TAG_W-1:0]  dest_tag;
	logic [RS_SIZE-1:0][ROB_IDX_W-1:0]  rob_idx;
	logic [RS_SIZE-1:0][ALU_FUNC_W-1:0] alu_func;

	logic [ISSUE_PORTS-1:0] has_credit, issued;

	////////////////////////////////////////////////////////////////////
	// dispatch
	////////////////////////////////////////////////////////////////////
	rs_operand_bypass bypass1 (
		.opa(inst1_opa), .opb(inst1_opb),
		.opa_ready(inst1_opa_ready), .opb_ready(inst1_opb_ready),
		.cdb1_valid(cdb1_valid), .cdb1_tag(cdb1_tag), .cdb1_value(cdb1_value),
		.cdb2_valid(cdb2_valid), .cdb2_tag(cdb2_tag), .cdb2_value(cdb2_value),
		.opa_out(b1_opa), .opb_out(b1_opb),
		.opa_ready_out(b1_opa_ready), .opb_ready_out(b1_opb_ready)
	);

	rs_operand_bypass bypass2 (
		.opa(inst2_opa), .opb(inst2_opb),
		.opa_ready(inst2_opa_ready), .opb_ready(inst2_opb_ready),
		.cdb1_valid(cdb1_valid), .cdb1_tag(cdb1_tag), .cdb1_value(cdb1_value),
		.cdb2_valid(cdb2_valid), .cdb2_tag(cdb2_tag), .cdb2_value(cdb2_value),
		.opa_out(b2_opa), .opb_out(b2_opb),
		.opa_ready_out(b2_opa_ready), .opb_ready_out(b2_opb_ready)
	);

	rs_alloc alloc (
		.busy(busy), .inst1_valid(inst1_valid), .inst2_valid(inst2_valid),
		.load1(load1), .load2(load2), .free_level(free_level)
	);

	////////////////////////////////////////////////////////////////////
	// entries
	////////////////////////////////////////////////////////////////////
	for (genvar i = 0; i < RS_SIZE; i++) begin : g_entry
		rs_entry entry (
			.clock(clock), .reset(reset),
			.load1(load1[i]), .load2(load2[i]),
			.inst1_dest_tag(inst1_dest_tag), .inst1_opa(b1_opa), .inst1_opb(b1_opb),
			.inst1_opa_ready(b1_opa_ready), .inst1_opb_ready(b1_opb_ready),
			.inst1_rob_idx(inst1_rob_idx), .inst1_alu_func(inst1_alu_func),
			.inst1_fu_class(inst1_fu_class),
			.inst2_dest_tag(inst2_dest_tag), .inst2_opa(b2_opa), .inst2_opb(b2_opb),
			.inst2_opa_ready(b2_opa_ready), .inst2_opb_ready(b2_opb_ready),
			.inst2_rob_idx(inst2_rob_idx), .inst2_alu_func(inst2_alu_func),
			.inst2_fu_class(inst2_fu_class),
			.cdb1_valid(cdb1_valid), .cdb1_tag(cdb1_tag), .cdb1_value(cdb1_value),
			.cdb2_valid(cdb2_valid), .cdb2_tag(cdb2_tag), .cdb2_value(cdb2_value),
			.issue_grant(issue_grant[i]), .flush_thread(flush_thread),
			.busy(busy[i]), .ready(ready[i]), .fu_class(fu_class[i]),
			.opa_value(opa_value[i]), .opb_value(opb_value[i]),
			.dest_tag(dest_tag[i]), .rob_idx(rob_idx[i]), .alu_func(alu_func[i])
		);
	end

	////////////////////////////////////////////////////////////////////
	// issue
	////////////////////////////////////////////////////////////////////
	rs_fu_credits credits (
		.clock(clock), .reset(reset),
		.issued(issued), .credit_return(credit_return), .has_credit(has_credit)
	);

	rs_issue_select select (
		.ready(ready), .fu_class(fu_class),
		.opa_value(opa_value), .opb_value(opb_value),
		.dest_tag(dest_tag), .rob_idx(rob_idx), .alu_func(alu_func),
		.has_credit(has_credit),
		.issue_grant(issue_grant), .issue_valid(issue_valid), .issued(issued),
		.issue_opa(issue_opa), .issue_opb(issue_opb),
		.issue_dest_tag(issue_dest_tag), .issue_rob_idx(issue_rob_idx),
		.issue_alu_func(issue_alu_func)
	);

endmodule

// ==== tb_rs.sv ====
// reservation station testbench
//   clock, reset and a Galois LFSR for the random stimulus
//   random dual dispatch, CDB broadcasts, credit returns and thread flushes
//   reference list of outstanding instructions with its own credit counts
//   negedge assertions on free level, issue valids and issue payloads

module tb_rs;
	timeunit 1ns;
	timeprecision 100ps;
	import rs_pkg::*;

	localparam int RESET_CYCLES  = 16;
	localparam int RANDOM_CYCLES = 440;
	localparam int FILL_CYCLES   = 24;
	localparam int DRAIN_CYCLES  = 60;	// rough bound for one drain
	localparam int LIMIT = RESET_CYCLES + RANDOM_CYCLES + FILL_CYCLES + 2 * DRAIN_CYCLES + 200;
	localparam int SLOT_W = 1 + PRF_TAG_W + 2 * DATA_W + 2 + ROB_IDX_W + ALU_FUNC_W + FU_CLASS_W;

	logic                                   clock = 1'b0;
	logic                                   reset;
	logic                                   inst1_valid, inst2_valid;
	logic [PRF_TAG_W-1:0]                   inst1_dest_tag, inst2_dest_tag;
	operand_t                               inst1_opa, inst1_opb, inst2_opa, inst2_opb;
	logic                                   inst1_opa_ready, inst1_opb_ready;
	logic                                   inst2_opa_ready, inst2_opb_ready;
	logic [ROB_IDX_W-1:0]                   inst1_rob_idx, inst2_rob_idx;
	logic [ALU_FUNC_W-1:0]                  inst1_alu_func, inst2_alu_func;
	logic [FU_CLASS_W-1:0]                  inst1_fu_class, inst2_fu_class;
	logic                                   cdb1_valid, cdb2_valid;
	logic [PRF_TAG_W-1:0]                   cdb1_tag, cdb2_tag;
	logic [DATA_W-1:0]                      cdb1_value, cdb2_value;
	logic [1:0]                             flush_thread;
	logic [ISSUE_PORTS-1:0]                 credit_return, issue_valid;
	logic [FREE_W-1:0]                      free_level;
	logic [ISSUE_PORTS-1:0][DATA_W-1:0]     issue_opa, issue_opb;
	logic [ISSUE_PORTS-1:0][PRF_TAG_W-1:0]  issue_dest_tag;
	logic [ISSUE_PORTS-1:0][ROB_IDX_W-1:0]  issue_rob_idx;
	logic [ISSUE_PORTS-1:0][ALU_FUNC_W-1:0] issue_alu_func;

	// reference list, one slot per outstanding instruction
	logic                   m_v    [RS_SIZE];
	logic                   m_ar   [RS_SIZE];
	logic                   m_br   [RS_SIZE];
	logic [DATA_W-1:0]      m_a    [RS_SIZE];	// value, or tag in the low bits
	logic [DATA_W-1:0]      m_b    [RS_SIZE];
	logic [PRF_TAG_W-1:0]   m_dest [RS_SIZE];
	logic [ROB_IDX_W-1:0]   m_rob  [RS_SIZE];
	logic [ALU_FUNC_W-1:0]  m_fn   [RS_SIZE];
	logic [FU_CLASS_W-1:0]  m_cls  [RS_SIZE];
	int                     m_cred [ISSUE_PORTS];
	int                     n_out;
	logic [ISSUE_PORTS-1:0] hit, want;
	logic [FREE_W-1:0]      exp_free;
	logic [15:0]            lfsr = 16'd90;
	logic [PRF_TAG_W-1:0]   next_dest = '0;
	int                     cycles = 0;

	rs_top UUT (.*);

	always #10 clock = ~clock;

	//////////////////////////////////////////////////////////////////////
	// failure reporting
	//////////////////////////////////////////////////////////////////////
	task automatic fail_now();
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		$display("** Error at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
		fail_now();
	endtask

	task automatic stop_run(input string why);
		$display("%s", why);
		fail_now();
	endtask

	// galois lfsr, one step per bit taken
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r    = {r[62:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 16'hB400 : 16'h0000);
		end
		return r;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////
	// pending operand picks up a CDB value, cdb1 first
	function automatic logic [DATA_W:0] capture(input logic [DATA_W-1:0] word, input logic rdy);
		if (!rdy && cdb1_valid && word[PRF_TAG_W-1:0] == cdb1_tag)
			return {1'b1, cdb1_value};
		else if (!rdy && cdb2_valid && word[PRF_TAG_W-1:0] == cdb2_tag)
			return {1'b1, cdb2_value};
		else
			return {rdy, word};
	endfunction

	// may issue on port p this cycle
	function automatic bit live(input int i, input int p);
		return m_v[i] && m_ar[i] && m_br[i] && m_cls[i] == 2'(p)
			&& !flush_thread[m_rob[i][ROB_IDX_W-1]];
	endfunction

	function automatic bit pays(input int i, input int p);
		return m_a[i] == issue_opa[p] && m_b[i] == issue_opb[p]
			&& m_dest[i] == issue_dest_tag[p] && m_rob[i] == issue_rob_idx[p]
			&& m_fn[i] == issue_alu_func[p];
	endfunction

	task automatic add_inst(input bit s);
		int k;
		k = 0;
		while (k < RS_SIZE && m_v[k])
			k++;
		if (k < RS_SIZE) begin
			m_v[k] = 1'b1;
			{m_ar[k], m_a[k]} = capture(s ? inst2_opa : inst1_opa,
				s ? inst2_opa_ready : inst1_opa_ready);	// dispatch-time bypass
			{m_br[k], m_b[k]} = capture(s ? inst2_opb : inst1_opb,
				s ? inst2_opb_ready : inst1_opb_ready);
			m_dest[k] = s ? inst2_dest_tag : inst1_dest_tag;
			m_rob[k]  = s ? inst2_rob_idx : inst1_rob_idx;
			m_fn[k]   = s ? inst2_alu_func : inst1_alu_func;
			m_cls[k]  = s ? inst2_fu_class : inst1_fu_class;
		end
	endtask

	always @(posedge clock) begin : model_update
		bit done;
		if (reset) begin
			for (int i = 0; i < RS_SIZE; i++)
				m_v[i] = 1'b0;
			for (int p = 0; p < ISSUE_PORTS; p++)
				m_cred[p] = CREDITS_PER_FU;
		end else begin
			for (int p = 0; p < ISSUE_PORTS; p++) begin
				done = 1'b0;
				for (int i = 0; i < RS_SIZE; i++) begin
					if (issue_valid[p] && !done && live(i, p) && pays(i, p)) begin
						m_v[i] = 1'b0;
						done   = 1'b1;
					end
				end
				m_cred[p] = m_cred[p] - int'(issue_valid[p]) + int'(credit_return[p]);
			end
			for (int i = 0; i < RS_SIZE; i++) begin
				if (m_v[i] && flush_thread[m_rob[i][ROB_IDX_W-1]])
					m_v[i] = 1'b0;
				if (m_v[i]) begin
					{m_ar[i], m_a[i]} = capture(m_a[i], m_ar[i]);	// wakeup
					{m_br[i], m_b[i]} = capture(m_b[i], m_br[i]);
				end
			end
			if (inst1_valid)
				add_inst(1'b0);
			if (inst2_valid)
				add_inst(1'b1);
		end
	end

	always_comb begin
		n_out = 0;
		hit   = '0;
		want  = '0;
		for (int i = 0; i < RS_SIZE; i++) begin
			n_out += int'(m_v[i]);
			for (int p = 0; p < ISSUE_PORTS; p++) begin
				if (live(i, p) && m_cred[p] > 0)
					want[p] = 1'b1;
				if (live(i, p) && pays(i, p))
					hit[p] = 1'b1;
			end
		end
		exp_free = (RS_SIZE - n_out >= 2) ? 2'd2 : FREE_W'(RS_SIZE - n_out);
	end

	//////////////////////////////////////////////////////////////////////
	// checks, sampled at the falling edge where everything is settled
	//////////////////////////////////////////////////////////////////////
	a_free: assert property (@(negedge clock) disable iff (reset) free_level == exp_free)
		else report_value("free_level", 64'(exp_free), 64'(free_level));
	a_valid: assert property (@(negedge clock) disable iff (reset) issue_valid == want)
		else report_value("issue_valid", 64'(want), 64'(issue_valid));
	a_payload: assert property (@(negedge clock) disable iff (reset) (issue_valid & ~hit) == '0)
		else stop_run("an issued payload matches no ready instruction of the port's class");

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT)
			stop_run($sformatf("timeout, run did not finish within %0d cycles", LIMIT));
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////
	// {valid, dest, opa, opb, opa_ready, opb_ready, rob_idx, alu_func, fu_class}
	function automatic logic [SLOT_W-1:0] new_slot(input bit en, input bit hi);
		logic [DATA_W-1:0] a, b;
		logic ar, br;
		ar = !hi && rand_bits(2) != 0;
		br = rand_bits(2) != 0;
		a  = rand_bits(64);
		b  = rand_bits(64);
		if (!ar)
			a[PRF_TAG_W-1:0] = hi ? 6'd63 : 6'(rand_bits(3));	// 63 only woken later
		if (!br)
			b[PRF_TAG_W-1:0] = 6'(rand_bits(3));
		if (en)
			next_dest = next_dest + 6'd1;
		return {en, next_dest, a, b, ar, br, 5'(rand_bits(5)), 5'(rand_bits(5)),
			2'(rand_bits(2) % 3)};
	endfunction

	task automatic run_cycle(input bit disp, input bit hi, input bit wake, input bit flush_ok,
			output bit idle);
		int avail;
		logic [SLOT_W-1:0] s1, s2;
		logic [ISSUE_PORTS-1:0] ret;
		logic [PRF_TAG_W-1:0] t1, t2;
		@(negedge clock);
		idle  = n_out == 0 && !inst1_valid && !inst2_valid;
		avail = int'(free_level) - int'(inst1_valid) - int'(inst2_valid);	// worst case next
		s1 = new_slot(disp && avail >= 1 && (hi || rand_bits(2) != 0), hi);
		s2 = new_slot(disp && avail >= 2 && (hi || rand_bits(1) == 1), hi);
		for (int p = 0; p < ISSUE_PORTS; p++)
			ret[p] = (m_cred[p] + int'(credit_return[p]) < CREDITS_PER_FU) && rand_bits(2) == 0;
		t1 = hi ? 6'd63 : 6'(rand_bits(3));
		t2 = rand_bits(1) ? t1 : 6'(rand_bits(3));	// same tag on both buses often
		@(posedge clock);
		{inst1_valid, inst1_dest_tag, inst1_opa, inst1_opb, inst1_opa_ready, inst1_opb_ready,
			inst1_rob_idx, inst1_alu_func, inst1_fu_class} <= s1;
		{inst2_valid, inst2_dest_tag, inst2_opa, inst2_opb, inst2_opa_ready, inst2_opb_ready,
			inst2_rob_idx, inst2_alu_func, inst2_fu_class} <= s2;
		cdb1_valid    <= wake && rand_bits(1);
		cdb1_tag      <= t1;
		cdb1_value    <= rand_bits(64);
		cdb2_valid    <= wake && rand_bits(1);
		cdb2_tag      <= t2;
		cdb2_value    <= rand_bits(64);
		flush_thread  <= (flush_ok && rand_bits(4) == 0) ? 2'(rand_bits(1) + 1) : 2'b00;
		credit_return <= ret;
	endtask

	// no dispatch, wake every tag range until the station is empty
	task automatic drain();
		bit idle;
		bit hi;
		hi = 1'b0;
		do begin
			run_cycle(1'b0, hi, 1'b1, 1'b0, idle);
			hi = !hi;
		end while (!idle);
	endtask

	initial begin
		bit idle;
		{inst1_valid, inst1_dest_tag, inst1_opa, inst1_opb, inst1_opa_ready, inst1_opb_ready,
			inst1_rob_idx, inst1_alu_func, inst1_fu_class} = '0;
		{inst2_valid, inst2_dest_tag, inst2_opa, inst2_opb, inst2_opa_ready, inst2_opb_ready,
			inst2_rob_idx, inst2_alu_func, inst2_fu_class} = '0;
		{cdb1_valid, cdb1_tag, cdb1_value, cdb2_valid, cdb2_tag, cdb2_value} = '0;
		flush_thread  = '0;
		credit_return = '0;
		reset         = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		repeat (RANDOM_CYCLES) run_cycle(1'b1, 1'b0, 1'b1, 1'b1, idle);
		drain();
		repeat (FILL_CYCLES) run_cycle(1'b1, 1'b1, 1'b0, 1'b0, idle);	// fill to capacity
		drain();
		$display("=== PASS ===");
		$finish;
	end

endmodule
